// File: verilog/pad_pkg.sv
`default_nettype none

package pad_pkg;

    // ====================
    // Poll frame timing
    // ====================

    localparam int POLL_CYCLES  = 128; // Clocks from one poll start to the next
    localparam int LATCH_CYCLES = 6;   // Width of the latch pulse
    localparam int SLOT_CYCLES  = 4;   // Clocks per bit slot, low half then high half
    localparam int FRAME_BITS   = 16;  // Bits shifted out of the pad per frame

    localparam int BUTTON_COUNT = 12;  // Buttons reported to the processor

    // Counter widths follow from the timing above
    localparam int POLL_CNT_W  = $clog2(POLL_CYCLES);
    localparam int PHASE_CNT_W = $clog2((LATCH_CYCLES > SLOT_CYCLES) ?
                                        LATCH_CYCLES : SLOT_CYCLES);
    localparam int BIT_INDEX_W = $clog2(FRAME_BITS);

    // ====================
    // Sequencer states
    // ====================

    typedef enum logic [1:0] {
        POLL_IDLE,  // Waiting for the next poll start
        POLL_LATCH, // Latch pulse high
        POLL_SHIFT  // Pad clock running over the bit slots
    } poll_state_t;

endpackage

`default_nettype wire

// File: verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int AXIL_DATA_W = 32; // Read data width
    localparam int AXIL_ADDR_W = 4;  // Byte address width

    // ====================
    // Register map
    // ====================

    localparam logic [AXIL_ADDR_W-1:0] REG_BUTTONS = 4'h0; // Buttons held in the last frame
    localparam logic [AXIL_ADDR_W-1:0] REG_PRESSED = 4'h4; // Sticky press flags, clear on read
    localparam logic [AXIL_ADDR_W-1:0] REG_FRAMES  = 4'h8; // Completed frame count

    // ====================
    // Read responses
    // ====================

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire

// File: verilog/pad_links_if.sv
`timescale 1ns/1ns
`default_nettype none

// Slot timing from the sequencer to the capture stage
interface pad_slot_if;
    import pad_pkg::*;

    logic                   frame_start; // One cycle at the start of the latch
    logic                   sample;      // Last low cycle of each slot
    logic [BIT_INDEX_W-1:0] bit_index;   // Valid together with sample
    logic                   frame_end;   // Cycle after the sixteenth sample

    modport source (
        output frame_start,
        output sample,
        output bit_index,
        output frame_end
    );

    modport sink (
        input frame_start,
        input sample,
        input bit_index,
        input frame_end
    );
endinterface

// Button registers shared by the tracker and the read port
interface button_state_if;
    import pad_pkg::*;

    logic [BUTTON_COUNT-1:0] held;
    logic [BUTTON_COUNT-1:0] pressed;
    logic [31:0]             frames;
    logic                    clear_pressed; // Read of the press flags accepted

    modport tracker (output held, output pressed, output frames, input clear_pressed);
    modport reader (input held, input pressed, input frames, output clear_pressed);
endinterface

`default_nettype wire

// File: verilog/pad_poll_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module pad_poll_sequencer (
    input  logic       clk,
    input  logic       aresetn,
    pad_slot_if.source slot,
    output logic       pad_latch,
    output logic       pad_clk
);
    import pad_pkg::*;

    logic [POLL_CNT_W-1:0]  poll_cnt;
    logic                   poll_start;
    poll_state_t            state;
    poll_state_t            state_d;
    logic [PHASE_CNT_W-1:0] phase_cnt;
    logic [PHASE_CNT_W-1:0] phase_d;
    logic [BIT_INDEX_W-1:0] bit_cnt;
    logic [BIT_INDEX_W-1:0] bit_d;

    // ====================
    // Poll period
    // ====================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            poll_cnt <= '0;
        end else if (poll_cnt == POLL_CNT_W'(POLL_CYCLES - 1)) begin
            poll_cnt <= '0;
        end else begin
            poll_cnt <= poll_cnt + 1'b1;
        end
    end

    assign poll_start = (poll_cnt == '0); // Also true in the first cycle out of reset

    // ====================
    // Frame FSM
    // ====================

    always_comb begin
        state_d = state;
        phase_d = phase_cnt;
        bit_d   = bit_cnt;
        case (state)
            POLL_IDLE: begin
                if (poll_start) begin
                    state_d = POLL_LATCH;
                    phase_d = '0;
                end
            end
            POLL_LATCH: begin
                if (phase_cnt == PHASE_CNT_W'(LATCH_CYCLES - 1)) begin
                    state_d = POLL_SHIFT; // Slots follow the latch with no gap
                    phase_d = '0;
                    bit_d   = '0;
                end else begin
                    phase_d = phase_cnt + 1'b1;
                end
            end
            POLL_SHIFT: begin
                if (phase_cnt == PHASE_CNT_W'(SLOT_CYCLES - 1)) begin
                    phase_d = '0;
                    if (bit_cnt == BIT_INDEX_W'(FRAME_BITS - 1)) begin
                        state_d = POLL_IDLE;
                    end else begin
                        bit_d = bit_cnt + 1'b1;
                    end
                end else begin
                    phase_d = phase_cnt + 1'b1;
                end
            end
            default: state_d = POLL_IDLE;
        endcase
    end

    // Outputs are registered from the next state so the pad pins never glitch
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state            <= POLL_IDLE;
            phase_cnt        <= '0;
            bit_cnt          <= '0;
            pad_latch        <= 1'b0;
            pad_clk          <= 1'b0;
            slot.frame_start <= 1'b0;
            slot.sample      <= 1'b0;
            slot.frame_end   <= 1'b0;
        end else begin
            state            <= state_d;
            phase_cnt        <= phase_d;
            bit_cnt          <= bit_d;
            pad_latch        <= (state_d == POLL_LATCH);
            pad_clk          <= (state_d == POLL_SHIFT) &&
                                (phase_d >= PHASE_CNT_W'(SLOT_CYCLES / 2)); // High half
            slot.frame_start <= (state == POLL_IDLE) && (state_d == POLL_LATCH);
            slot.sample      <= (state_d == POLL_SHIFT) &&
                                (phase_d == PHASE_CNT_W'(SLOT_CYCLES / 2 - 1));
            slot.frame_end   <= slot.sample &&
                                (slot.bit_index == BIT_INDEX_W'(FRAME_BITS - 1));
        end
    end

    always_ff @(posedge clk) begin
        slot.bit_index <= bit_d; // Only meaningful while sample is high
    end

endmodule

`default_nettype wire

// File: verilog/pad_shift_capture.sv
`timescale 1ns/1ns
`default_nettype none

module pad_shift_capture (
    input  logic                             clk,
    input  logic                             aresetn,
    pad_slot_if.sink                         slot,
    input  logic                             pad_data,
    output logic                             frame_valid,
    output logic [pad_pkg::BUTTON_COUNT-1:0] frame_buttons
);
    import pad_pkg::*;

    logic [FRAME_BITS-1:0] frame_bits; // Bit 0 is the first bit out of the pad

    // ====================
    // Bit assembly
    // ====================

    always_ff @(posedge clk) begin
        if (slot.frame_start) begin
            frame_bits <= '0;
        end else if (slot.sample) begin
            frame_bits[slot.bit_index] <= ~pad_data; // Pad data is low for a pressed button
        end
    end

    // Bits above BUTTON_COUNT are shifted in but never reported
    always_ff @(posedge clk) begin
        if (slot.frame_end) begin
            frame_buttons <= frame_bits[BUTTON_COUNT-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= slot.frame_end; // Same cycle as the new frame_buttons
        end
    end

endmodule

`default_nettype wire

// File: verilog/button_event_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module button_event_tracker (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             frame_valid,
    input  logic [pad_pkg::BUTTON_COUNT-1:0] frame_buttons,
    button_state_if.tracker                  state
);
    import pad_pkg::*;

    logic [BUTTON_COUNT-1:0] new_press;

    // A press counts only on the frame where the button goes from released to held
    assign new_press = frame_valid ? (frame_buttons & ~state.held) : '0;

    // ====================
    // Button registers
    // ====================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state.held    <= '0;
            state.pressed <= '0;
            state.frames  <= '0;
        end else begin
            if (frame_valid) begin
                state.held   <= frame_buttons;
                state.frames <= state.frames + 1'b1;
            end
            if (state.clear_pressed) begin
                state.pressed <= new_press; // A press in the clear cycle survives
            end else begin
                state.pressed <= state.pressed | new_press;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/axil_read_port.sv
`timescale 1ns/1ns
`default_nettype none

module axil_read_port (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
    input  logic                             s_axil_arvalid,
    output logic                             s_axil_arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
    output axil_pkg::axil_resp_t             s_axil_rresp,
    output logic                             s_axil_rvalid,
    input  logic                             s_axil_rready,
    button_state_if.reader                   state
);
    import axil_pkg::*;

    logic                   rd_accept;
    logic [AXIL_DATA_W-1:0] rdata_d;
    axil_resp_t             rresp_d;

    // ====================
    // Address channel
    // ====================

    assign s_axil_arready = !s_axil_rvalid; // One read in flight at a time
    assign rd_accept      = s_axil_arvalid && s_axil_arready;

    // The tracker sees the clear in the same cycle that the old flags are captured
    assign state.clear_pressed = rd_accept && (s_axil_araddr == REG_PRESSED);

    always_comb begin
        rdata_d = '0;
        rresp_d = RESP_OKAY;
        case (s_axil_araddr)
            REG_BUTTONS: rdata_d = AXIL_DATA_W'(state.held);
            REG_PRESSED: rdata_d = AXIL_DATA_W'(state.pressed);
            REG_FRAMES:  rdata_d = AXIL_DATA_W'(state.frames);
            default:     rresp_d = RESP_SLVERR; // Unmapped address reads as zero
        endcase
    end

    // ====================
    // Data channel
    // ====================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0; // Transfer done, arready returns next cycle
        end
    end

    // Response is captured once and held through any back-pressure
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_axil_rdata <= rdata_d;
            s_axil_rresp <= rresp_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pad_reader_top.sv
`timescale 1ns/1ns
`default_nettype none

module pad_reader_top (
    input  logic                             clk,
    input  logic                             aresetn,

    input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
    input  logic                             s_axil_arvalid,
    output logic                             s_axil_arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
    output axil_pkg::axil_resp_t             s_axil_rresp,
    output logic                             s_axil_rvalid,
    input  logic                             s_axil_rready,

    input  logic                             pad_data,
    output logic                             pad_clk,
    output logic                             pad_latch
);
    import pad_pkg::*;

    logic                    frame_valid;
    logic [BUTTON_COUNT-1:0] frame_buttons;

    pad_slot_if     slot_if ();
    button_state_if state_if ();

    // ====================
    // Pad side
    // ====================

    pad_poll_sequencer u_sequencer (
        .clk       (clk),
        .aresetn   (aresetn),
        .slot      (slot_if.source),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk)
    );

    pad_shift_capture u_capture (
        .clk           (clk),
        .aresetn       (aresetn),
        .slot          (slot_if.sink),
        .pad_data      (pad_data),
        .frame_valid   (frame_valid),
        .frame_buttons (frame_buttons)
    );

    // ====================
    // Processor side
    // ====================

    button_event_tracker u_tracker (
        .clk           (clk),
        .aresetn       (aresetn),
        .frame_valid   (frame_valid),
        .frame_buttons (frame_buttons),
        .state         (state_if.tracker)
    );

    axil_read_port u_read_port (
        .clk            (clk),
        .aresetn        (aresetn),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .state          (state_if.reader)
    );

endmodule

`default_nettype wire

// File: bench/pad_reader_props.sv
`timescale 1ns/1ns
`default_nettype none

module pad_reader_props (
    input logic                             clk,
    input logic                             aresetn,
    input logic                             pad_latch,
    input logic                             pad_clk,
    input logic                             s_axil_arready,
    input logic                             s_axil_rvalid,
    input logic                             s_axil_rready,
    input logic [axil_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
    input logic [1:0]                       s_axil_rresp
);

    // ====================
    // Pad pins
    // ====================

    latch_clk_exclusive: assert property (@(posedge clk) disable iff (!aresetn)
        !(pad_latch && pad_clk))
        else $error("pad_latch and pad_clk are high together");

    clk_quiet_in_reset: assert property (@(posedge clk) !aresetn |=> !pad_clk)
        else $error("pad_clk is high during reset");

    // ====================
    // AXI read channel
    // ====================

    rvalid_held: assert property (@(posedge clk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
        else $error("Read response dropped or changed before rready");

    arready_blocked: assert property (@(posedge clk) disable iff (!aresetn)
        s_axil_rvalid |-> !s_axil_arready)
        else $error("arready is high while a response is pending");

endmodule

bind pad_reader_top pad_reader_props u_props (
    .clk            (clk),
    .aresetn        (aresetn),
    .pad_latch      (pad_latch),
    .pad_clk        (pad_clk),
    .s_axil_arready (s_axil_arready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp)
);

`default_nettype wire

// File: bench/pad_reader_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pad_reader_tb;
    import pad_pkg::*;
    import axil_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int RESP_LIMIT   = 16;                  // Cycles allowed for each AXI handshake
    localparam int TEST_POLLS   = 2 + 8 + 4 + 1 + 16;  // Poll periods waited by the tests
    localparam int WATCHDOG_NS  = (TEST_POLLS + 6) * POLL_CYCLES * CLK_PERIOD;

    logic                   clk;
    logic                   aresetn;
    logic [AXIL_ADDR_W-1:0] s_axil_araddr;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    logic [AXIL_DATA_W-1:0] s_axil_rdata;
    logic [1:0]             s_axil_rresp;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;
    logic                   pad_data;
    logic                   pad_clk;
    logic                   pad_latch;

    logic [15:0] press_mask;                 // Bit n set means button n is held down
    logic [3:0]  pad_bit = 4'd0;             // Bit the pad presents on pad_data
    logic [31:0] lfsr_state = 32'hc717_08c0;
    int          latch_count = 0;
    int          accept_latches;             // Latch count at the last address acceptance
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          checks_at_open;
    int          errors_at_open;

    pad_reader_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Pad model
    // ====================

    always @(posedge pad_latch or posedge pad_clk) begin
        if (pad_latch) begin
            pad_bit <= 4'd0;           // Bit 0 from the latch until the first pad clock rise
        end else begin
            pad_bit <= pad_bit + 4'd1;
        end
    end

    assign pad_data = ~press_mask[pad_bit]; // Low for a pressed button

    always @(posedge pad_latch) begin
        latch_count <= latch_count + 1;
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_mask(output logic [15:0] mask);
        for (int i = 0; i < 16; i++) begin
            mask[i]    = lfsr_state[0]; // One step per bit taken
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic open_test();
        checks_at_open = check_count;
        errors_at_open = error_count;
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("[%0t ns] %s: %0d checks, %0d errors", $time, name,
                 check_count - checks_at_open, error_count - errors_at_open);
    endtask

    // Reads start two cycles after a latch rise, far from the frame update
    task automatic wait_polls(input int polls);
        repeat (polls) @(posedge pad_latch);
    endtask

    task automatic axil_read(input logic [3:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = (stall == 0);
        @(negedge clk);
        while (!s_axil_arready && cycles < RESP_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s_axil_arready) begin
            $display("ERROR at %0t ns: read address 0x%0h was never accepted", $time, addr);
            error_count++;
        end
        @(posedge clk);                   // Address accepted on this edge
        #1;
        accept_latches = latch_count;
        s_axil_arvalid = 1'b0;
        cycles         = 0;
        @(negedge clk);
        while (!s_axil_rvalid && cycles < RESP_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s_axil_rvalid) begin
            $display("ERROR at %0t ns: no read response for address 0x%0h", $time, addr);
            error_count++;
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        repeat (stall) begin
            @(negedge clk);
            check_value("s_axil_rvalid", 32'(s_axil_rvalid), 32'd1);
            check_value("s_axil_rdata", s_axil_rdata, data);
            check_value("s_axil_rresp", 32'(s_axil_rresp), 32'(resp));
            check_value("s_axil_arready", 32'(s_axil_arready), 32'd0);
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            s_axil_rready = 1'b1;
        end
        @(posedge clk);                   // Data transfer
        @(negedge clk);
        check_value("s_axil_rvalid after transfer", 32'(s_axil_rvalid), 32'd0);
    endtask

    task automatic read_and_compare(input logic [3:0] addr, input string name,
                                    input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, 0, data, resp);
        check_value(name, data, expected);
        check_value({name, " rresp"}, 32'(resp), 32'(RESP_OKAY));
    endtask

    // ====================
    // Tests
    // ====================

    task automatic idle_after_reset();
        open_test();
        aresetn = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("pad_latch in reset", 32'(pad_latch), 32'd0);
            check_value("pad_clk in reset", 32'(pad_clk), 32'd0);
        end
        aresetn = 1'b1;
        read_and_compare(REG_BUTTONS, "REG_BUTTONS", 32'd0);
        read_and_compare(REG_PRESSED, "REG_PRESSED", 32'd0);
        close_test("idle after reset");
    endtask

    task automatic bit_order_and_inversion();
        open_test();
        press_mask = 16'hc5a3;                 // Upper nibble is never reported
        wait_polls(2);
        read_and_compare(REG_BUTTONS, "REG_BUTTONS", 32'h0000_05a3);
        close_test("bit order and inversion");
    endtask

    task automatic press_flags();
        logic [31:0] data;
        logic [1:0]  resp;
        open_test();
        press_mask = 16'h0000;
        wait_polls(2);
        axil_read(REG_PRESSED, 0, data, resp); // Clears flags left by earlier tests
        press_mask = 16'h3a69;
        wait_polls(2);
        read_and_compare(REG_PRESSED, "REG_PRESSED first press", 32'h0000_0a69);
        press_mask = 16'h0000;
        wait_polls(2);
        read_and_compare(REG_PRESSED, "REG_PRESSED after release", 32'd0);
        press_mask = 16'h3a69;
        wait_polls(2);
        read_and_compare(REG_PRESSED, "REG_PRESSED pressed again", 32'h0000_0a69);
        close_test("press flags");
    endtask

    task automatic frame_counting();
        logic [31:0] frames_a;
        logic [31:0] frames_b;
        logic [1:0]  resp;
        int          latches_a;
        open_test();
        wait_polls(1);
        axil_read(REG_FRAMES, 0, frames_a, resp);
        latches_a = accept_latches;
        wait_polls(3);
        axil_read(REG_FRAMES, 0, frames_b, resp);
        check_value("REG_FRAMES increase", frames_b - frames_a,
                    32'(accept_latches - latches_a));
        close_test("frame counting");
    endtask

    task automatic backpressure_and_error();
        logic [31:0] data;
        logic [1:0]  resp;
        open_test();
        wait_polls(1);
        axil_read(REG_FRAMES, 6, data, resp);   // rready held low for six cycles
        // The frame begun by the last latch is still shifting when the read is accepted
        check_value("REG_FRAMES stalled", data, 32'(accept_latches - 1));
        check_value("REG_FRAMES stalled rresp", 32'(resp), 32'(RESP_OKAY));
        axil_read(4'd12, 0, data, resp);
        check_value("unmapped rdata", data, 32'd0);
        check_value("unmapped rresp", 32'(resp), 32'(RESP_SLVERR));
        close_test("back-pressure and error");
    endtask

    task automatic random_masks();
        logic [15:0] mask;
        open_test();
        for (int n = 0; n < 8; n++) begin
            draw_mask(mask);
            press_mask = mask;
            wait_polls(2);
            read_and_compare(REG_BUTTONS, "REG_BUTTONS random", 32'(mask[BUTTON_COUNT-1:0]));
        end
        close_test("random masks");
    endtask

    // ====================
    // Sequence and watchdog
    // ====================

    initial begin
        aresetn        = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        press_mask     = 16'h0000;
        idle_after_reset();
        bit_order_and_inversion();
        press_flags();
        frame_counting();
        backpressure_and_error();
        random_masks();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test did not finish", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/pad_pkg.sv
verilog/axil_pkg.sv
verilog/pad_links_if.sv
verilog/pad_poll_sequencer.sv
verilog/pad_shift_capture.sv
verilog/button_event_tracker.sv
verilog/axil_read_port.sv
verilog/pad_reader_top.sv
bench/pad_reader_props.sv
bench/pad_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pad_reader_tb -f sim.f -o pad_reader_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pad_reader_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
